// File: verilog/capi_unroll_pkg.sv
// shared widths, skid-stage states and the beat-count helper
`default_nettype none

package capi_unroll_pkg;

   // default payload widths
   parameter int c_dwidth = 32;
   parameter int c_iwidth = 8;
   parameter int c_cwidth = 4;

   // skid stage occupancy
   // empty: nothing held
   // full: output register valid
   // skid: output and skid registers both valid
   typedef enum logic [1:0] {
      ST_EMPTY = 2'd0,
      ST_FULL  = 2'd1,
      ST_SKID  = 2'd2
   } burp_state_e;

   // number of beats for a count field, zero means 2^cwidth
   function automatic int unsigned beat_count(input int unsigned count,
                                              input int unsigned cwidth);
      int unsigned n;
      n = (count == 0) ? (32'd1 << cwidth) : count;
      return n;
   endfunction

endpackage

`default_nettype wire

// File: verilog/base_primux.sv
// fixed priority valid/ready mux, highest numbered way wins
`timescale 1ns/100ps
`default_nettype none

module base_primux #(
   parameter int ways  = 2,
   parameter int width = 1
) (
   input  wire  [ways-1:0]       i_v,
   input  wire  [ways*width-1:0] i_d,
   output logic [ways-1:0]       i_r,
   output logic                  o_v,
   output logic [width-1:0]      o_d,
   input  wire                   o_r
);

   // one-hot of the chosen way
   logic [ways-1:0] sel_oh;

   // scan upward so the highest valid way overrides lower ones
   always_comb begin
      sel_oh = '0;
      o_d    = i_d[width-1:0];
      for (int k = 0; k < ways; k++) begin
         if (i_v[k]) begin
            sel_oh    = '0;
            sel_oh[k] = 1'b1;
            o_d       = i_d[k*width +: width];
         end
      end
   end

   // any valid way makes the output valid
   assign o_v = |i_v;

   // only the winner sees downstream ready
   // losers stall with their data held
   assign i_r = sel_oh & {ways{o_r}};

endmodule

`default_nettype wire

// File: verilog/base_alatch_burp.sv
// registered valid/ready stage with a one-entry skid buffer
// upstream ready comes straight from the state register
`timescale 1ns/100ps
`default_nettype none

module base_alatch_burp #(
   parameter int width = 1
) (
   input  wire              clk,
   input  wire              i_rst_n,
   input  wire              i_v,
   input  wire [width-1:0]  i_d,
   output logic             i_r,
   output logic             o_v,
   output logic [width-1:0] o_d,
   input  wire              o_r
);

   capi_unroll_pkg::burp_state_e state;
   capi_unroll_pkg::burp_state_e state_nxt;

   // output register and skid register
   logic [width-1:0] out_q;
   logic [width-1:0] skid_q;

   // handshakes on each side
   logic in_xfer;
   logic out_xfer;

   assign in_xfer  = i_v & i_r;
   assign out_xfer = o_v & o_r;

   // ready drops only once the skid slot is taken
   assign i_r = (state != capi_unroll_pkg::ST_SKID);
   assign o_v = (state != capi_unroll_pkg::ST_EMPTY);
   assign o_d = out_q;

   always_comb begin
      state_nxt = state;
      case (state)
         capi_unroll_pkg::ST_EMPTY: begin
            if (in_xfer)
               state_nxt = capi_unroll_pkg::ST_FULL;
         end
         capi_unroll_pkg::ST_FULL: begin
            // new item while downstream stalls goes to skid
            if (in_xfer && !out_xfer)
               state_nxt = capi_unroll_pkg::ST_SKID;
            else if (!in_xfer && out_xfer)
               state_nxt = capi_unroll_pkg::ST_EMPTY;
         end
         capi_unroll_pkg::ST_SKID: begin
            // skid entry moves up when the head drains
            if (out_xfer)
               state_nxt = capi_unroll_pkg::ST_FULL;
         end
         default: begin
            state_nxt = capi_unroll_pkg::ST_EMPTY;
         end
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state <= capi_unroll_pkg::ST_EMPTY;
      end else begin
         state <= state_nxt;
      end
   end

   // payload path
   always_ff @(posedge clk) begin
      if (state == capi_unroll_pkg::ST_SKID) begin
         if (out_xfer)
            out_q <= skid_q;
      end else if (in_xfer) begin
         // head is free or leaving this cycle
         if (state == capi_unroll_pkg::ST_EMPTY || out_xfer)
            out_q <= i_d;
         else
            skid_q <= i_d;
      end
   end

endmodule

`default_nettype wire

// File: verilog/capi_read_unroll_cnt.sv
// unroll core: merge remainder with new requests, fork to output and feedback
`timescale 1ns/100ps
`default_nettype none

module capi_read_unroll_cnt #(
   parameter int dwidth = 32,
   parameter int iwidth = 8,
   parameter int cwidth = 4
) (
   input  wire               clk,
   input  wire               i_rst_n,

   // request in
   input  wire               i_req_v,
   input  wire  [dwidth-1:0] i_req_d,
   input  wire  [iwidth-1:0] i_req_i,
   input  wire  [cwidth-1:0] i_req_c,
   output logic              o_req_r,

   // beats out
   output logic              o_beat_v,
   output logic [dwidth-1:0] o_beat_d,
   output logic [iwidth-1:0] o_beat_i,
   output logic              o_beat_s,
   output logic              o_beat_e,
   input  wire               i_beat_r
);

   // data, index and count packed together
   localparam int dic_width = dwidth + iwidth + cwidth;

   // feedback stage output
   logic                 fb_v;
   logic                 fb_r;
   logic [dic_width-1:0] fb_dic;

   // merged beat
   logic                 s1_v;
   logic                 s1_r;
   logic [dwidth-1:0]    s1_d;
   logic [iwidth-1:0]    s1_i;
   logic [cwidth-1:0]    s1_c;
   logic                 s1_s;
   logic                 s1_e;
   logic [iwidth-1:0]    s1_ni;
   logic [cwidth-1:0]    s1_nc;
   logic [1:0]           arb_r;

   // fork sides, a toward the filter, b toward the output
   logic                 s1a_v;
   logic                 s1a_r;
   logic                 s1b_v;
   logic                 s1b_r;
   // filter output into the feedback stage
   logic                 s1c_v;
   logic                 s1c_r;

   logic [dwidth+iwidth+1:0] beat_q;

   // way 1 is the remainder, so it beats a new request
   // low data bit is the first flag, set only for new requests
   base_primux #(
      .ways  (2),
      .width (dic_width + 1)
   ) iarb1 (
      .i_v ({fb_v, i_req_v}),
      .i_d ({fb_dic, 1'b0, i_req_d, i_req_i, i_req_c, 1'b1}),
      .i_r (arb_r),
      .o_v (s1_v),
      .o_d ({s1_d, s1_i, s1_c, s1_s}),
      .o_r (s1_r)
   );

   assign fb_r    = arb_r[1];
   assign o_req_r = arb_r[0];

   // last beat when one beat remains
   assign s1_e  = (capi_unroll_pkg::beat_count(32'(s1_c), cwidth) == 1);
   // remainder moves one index on with one beat fewer
   // index wraps naturally at iwidth
   assign s1_ni = s1_i + iwidth'(1);
   assign s1_nc = s1_c - cwidth'(1);

   // fork: each side only fires when the other can take it too
   assign s1a_v = s1_v & s1b_r;
   assign s1b_v = s1_v & s1a_r;
   assign s1_r  = s1a_r & s1b_r;

   // filter drops the feedback copy of the last beat
   // and never blocks it
   assign s1c_v = s1a_v & ~s1_e;
   assign s1a_r = s1_e | s1c_r;

   base_alatch_burp #(
      .width (dic_width)
   ) ifdback (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_v     (s1c_v),
      .i_d     ({s1_d, s1_ni, s1_nc}),
      .i_r     (s1c_r),
      .o_v     (fb_v),
      .o_d     (fb_dic),
      .o_r     (fb_r)
   );

   // output register, one cycle after the merge
   base_alatch_burp #(
      .width (dwidth + iwidth + 2)
   ) iout (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_v     (s1b_v),
      .i_d     ({s1_d, s1_i, s1_e, s1_s}),
      .i_r     (s1b_r),
      .o_v     (o_beat_v),
      .o_d     (beat_q),
      .o_r     (i_beat_r)
   );

   assign o_beat_d = beat_q[dwidth+iwidth+1 -: dwidth];
   assign o_beat_i = beat_q[iwidth+1 -: iwidth];
   assign o_beat_e = beat_q[1];
   assign o_beat_s = beat_q[0];

endmodule

`default_nettype wire

// File: verilog/capi_read_unroll.sv
// read-response unroller top: input skid stage in front of the unroll core
`timescale 1ns/100ps
`default_nettype none

module capi_read_unroll #(
   parameter int dwidth = capi_unroll_pkg::c_dwidth,
   parameter int iwidth = capi_unroll_pkg::c_iwidth,
   parameter int cwidth = capi_unroll_pkg::c_cwidth
) (
   input  wire               clk,
   input  wire               i_rst_n,

   input  wire               i_req_v,
   input  wire  [dwidth-1:0] i_req_d,
   input  wire  [iwidth-1:0] i_req_i,
   input  wire  [cwidth-1:0] i_req_c,
   output logic              o_req_r,

   output logic              o_beat_v,
   output logic [dwidth-1:0] o_beat_d,
   output logic [iwidth-1:0] o_beat_i,
   output logic              o_beat_s,
   output logic              o_beat_e,
   input  wire               i_beat_r
);

   // registered request toward the core
   logic                     req_v;
   logic                     req_r;
   logic [dwidth-1:0]        req_d;
   logic [iwidth-1:0]        req_i;
   logic [cwidth-1:0]        req_c;

   // keeps o_req_r off the core's combinational arbitration
   base_alatch_burp #(
      .width (dwidth + iwidth + cwidth)
   ) iin (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_v     (i_req_v),
      .i_d     ({i_req_d, i_req_i, i_req_c}),
      .i_r     (o_req_r),
      .o_v     (req_v),
      .o_d     ({req_d, req_i, req_c}),
      .o_r     (req_r)
   );

   capi_read_unroll_cnt #(
      .dwidth (dwidth),
      .iwidth (iwidth),
      .cwidth (cwidth)
   ) iunroll (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_req_v  (req_v),
      .i_req_d  (req_d),
      .i_req_i  (req_i),
      .i_req_c  (req_c),
      .o_req_r  (req_r),
      .o_beat_v (o_beat_v),
      .o_beat_d (o_beat_d),
      .o_beat_i (o_beat_i),
      .o_beat_s (o_beat_s),
      .o_beat_e (o_beat_e),
      .i_beat_r (i_beat_r)
   );

endmodule

`default_nettype wire

// File: verification/tb_capi_read_unroll.sv
// testbench for the read-response unroller
// random requests and back-pressure checked against a beat queue model
`timescale 1ns/100ps
`default_nettype none

module tb_capi_read_unroll;

   localparam int dwidth = capi_unroll_pkg::c_dwidth;
   localparam int iwidth = capi_unroll_pkg::c_iwidth;
   localparam int cwidth = capi_unroll_pkg::c_cwidth;
   // expected beat: data, index, first, last
   localparam int bwidth = dwidth + iwidth + 2;
   localparam int n_steady = 24;
   localparam int n_random = 200;
   localparam int watchdog_cycles = (n_steady + n_random) * (1 << cwidth) * 4 + 200;
   // a few full-length requests in flight under 70% ready
   localparam int drain_cycles = 8 * (1 << cwidth) * 4;

   logic              clk;
   logic              i_rst_n;
   logic              i_req_v;
   logic [dwidth-1:0] i_req_d;
   logic [iwidth-1:0] i_req_i;
   logic [cwidth-1:0] i_req_c;
   logic              o_req_r;
   logic              o_beat_v;
   logic [dwidth-1:0] o_beat_d;
   logic [iwidth-1:0] o_beat_i;
   logic              o_beat_s;
   logic              o_beat_e;
   logic              i_beat_r;

   logic [bwidth-1:0] exp_q[$];
   int                errors;
   int                beats_checked;
   int                idle_cycles;
   // steady phase: ready held high, no request gaps
   logic              steady;
   logic              steady_seen;

   capi_read_unroll #(
      .dwidth (dwidth),
      .iwidth (iwidth),
      .cwidth (cwidth)
   ) i_dut (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_req_v  (i_req_v),
      .i_req_d  (i_req_d),
      .i_req_i  (i_req_i),
      .i_req_c  (i_req_c),
      .o_req_r  (o_req_r),
      .o_beat_v (o_beat_v),
      .o_beat_d (o_beat_d),
      .o_beat_i (o_beat_i),
      .o_beat_s (o_beat_s),
      .o_beat_e (o_beat_e),
      .i_beat_r (i_beat_r)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // offer one request and hold it until taken
   // returns 1 ns after the transfer edge
   task automatic send_request(input logic [dwidth-1:0] d,
                               input logic [iwidth-1:0] idx,
                               input logic [cwidth-1:0] cnt);
      i_req_v = 1'b1;
      i_req_d = d;
      i_req_i = idx;
      i_req_c = cnt;
      @(negedge clk);
      while (!o_req_r)
         @(negedge clk);
      @(posedge clk);
      #1;
      i_req_v = 1'b0;
   endtask

   // wait until every expected beat has been seen, bounded
   task automatic wait_drain();
      int n;
      n = 0;
      @(negedge clk);
      while (exp_q.size() != 0 && n < drain_cycles) begin
         @(negedge clk);
         n++;
      end
   endtask

   // monitor at the falling edge, where handshakes are settled
   always @(negedge clk) begin
      int                nbeats;
      logic [iwidth-1:0] idx;
      logic              first;
      logic              last;
      logic [bwidth-1:0] exp_b;
      if (i_rst_n) begin
         // model: a zero count means 2^cwidth beats
         if (i_req_v && o_req_r) begin
            nbeats = (i_req_c == '0) ? (1 << cwidth) : int'(i_req_c);
            for (int k = 0; k < nbeats; k++) begin
               idx   = i_req_i + iwidth'(k);
               first = (k == 0);
               last  = (k == nbeats - 1);
               exp_q.push_back({i_req_d, idx, first, last});
            end
         end
         if (o_beat_v && i_beat_r) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("beat with index %h arrived with no request outstanding", o_beat_i);
            end else begin
               exp_b = exp_q.pop_front();
               beats_checked++;
               if (o_beat_d !== exp_b[bwidth-1 -: dwidth]) begin
                  errors++;
                  $display("FAILED beat data: expected %h, actual %h",
                           exp_b[bwidth-1 -: dwidth], o_beat_d);
               end
               if (o_beat_i !== exp_b[iwidth+1 -: iwidth]) begin
                  errors++;
                  $display("FAILED beat index: expected %h, actual %h",
                           exp_b[iwidth+1 -: iwidth], o_beat_i);
               end
               if (o_beat_s !== exp_b[1]) begin
                  errors++;
                  $display("FAILED first flag: expected %b, actual %b", exp_b[1], o_beat_s);
               end
               if (o_beat_e !== exp_b[0]) begin
                  errors++;
                  $display("FAILED last flag: expected %b, actual %b", exp_b[0], o_beat_e);
               end
            end
         end
         // gap in the stream while beats are still owed
         if (steady) begin
            if (o_beat_v)
               steady_seen = 1'b1;
            else if (steady_seen && exp_q.size() != 0)
               idle_cycles++;
         end
      end
   end

   // downstream ready, about 70% high outside the steady phase
   initial begin
      i_beat_r = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (steady)
            i_beat_r = 1'b1;
         else
            i_beat_r = (($urandom % 10) < 7);
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles, %0d beats still expected",
               watchdog_cycles, exp_q.size());
      $display("Test FAILED");
      $finish;
   end

   initial begin
      int                gap;
      logic [cwidth-1:0] cnt;
      void'($urandom(32'h5633));
      errors        = 0;
      beats_checked = 0;
      idle_cycles   = 0;
      steady        = 1'b0;
      steady_seen   = 1'b0;
      i_rst_n       = 1'b0;
      i_req_v       = 1'b0;
      i_req_d       = '0;
      i_req_i       = '0;
      i_req_c       = '0;
      repeat (3) @(posedge clk);
      #1;
      i_rst_n = 1'b1;

      // idle state out of reset
      @(negedge clk);
      if (o_beat_v !== 1'b0) begin
         errors++;
         $display("FAILED reset o_beat_v: expected 0, actual %b", o_beat_v);
      end
      if (o_req_r !== 1'b1) begin
         errors++;
         $display("FAILED reset o_req_r: expected 1, actual %b", o_req_r);
      end

      // back-to-back requests, ready held high
      steady = 1'b1;
      @(posedge clk);
      #1;
      for (int k = 0; k < n_steady; k++) begin
         cnt = (k % 6 == 0) ? '0 : cwidth'($urandom);
         send_request(dwidth'($urandom), iwidth'($urandom), cnt);
      end
      wait_drain();
      steady = 1'b0;
      if (idle_cycles != 0) begin
         errors++;
         $display("FAILED steady stream idle cycles: expected 0, actual %0d", idle_cycles);
      end

      // random gaps and random back-pressure
      @(posedge clk);
      #1;
      for (int k = 0; k < n_random; k++) begin
         gap = int'($urandom % 4);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         cnt = (k % 8 == 0) ? '0 : cwidth'($urandom);
         send_request(dwidth'($urandom), iwidth'($urandom), cnt);
      end
      wait_drain();
      // a stray beat after the drain shows up in the monitor
      repeat (10) @(negedge clk);
      if (exp_q.size() != 0) begin
         errors++;
         $display("model queue still holds %0d beats at the end of the run", exp_q.size());
      end

      $display("errors: %0d, beats checked: %0d, steady idle cycles: %0d",
               errors, beats_checked, idle_cycles);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
verilog/capi_unroll_pkg.sv
verilog/base_primux.sv
verilog/base_alatch_burp.sv
verilog/capi_read_unroll_cnt.sv
verilog/capi_read_unroll.sv
verification/tb_capi_read_unroll.sv

// File: run.sh
#!/bin/sh
# build and run the unroller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
   -f vlog.f \
   --top-module tb_capi_read_unroll \
   -Mdir obj_dir \
   -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
   exit 0
else
   exit 1
fi
